//--- run_sim.sh
#!/bin/sh
# builds the bus fabric testbench with verilator and runs it.
# the exit status is the simulator's, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bus_system \
    -f vlog.f \
    -o sim_bus_system
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_bus_system
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- source/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder #(
    parameter int RAM_BITS = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    input  logic               cmd_wr,
    input  soc_pkg::addr_t     cmd_addr,
    input  soc_pkg::data_t     cmd_wdata,
    input  soc_pkg::mask_t     cmd_mask,
    lane_if.master             lanes,
    output logic               port_we,
    output logic               timer_we,
    output logic               acc_valid,
    output soc_pkg::region_t   acc_region,
    output logic               acc_unmapped
);

    soc_pkg::region_t region;
    logic             is_ram;
    logic             is_port;
    logic             is_timer;

    assign region = cmd_addr[$bits(soc_pkg::addr_t)-1:soc_pkg::REGION_LSB];

    assign is_ram   = (region == soc_pkg::REGION_RAM);
    assign is_port  = (region == soc_pkg::REGION_PORT);
    assign is_timer = (region == soc_pkg::REGION_TIMER);

    // ram lanes see every ram command, reads included.
    assign lanes.sel       = cmd_valid & is_ram;
    assign lanes.wr        = cmd_wr;
    assign lanes.word_addr = cmd_addr[RAM_BITS+1:2];
    assign lanes.wdata     = cmd_wdata;
    assign lanes.mask      = cmd_mask;

    // register blocks only care about writes.
    assign port_we  = cmd_valid & cmd_wr & is_port;
    assign timer_we = cmd_valid & cmd_wr & is_timer;

    assign acc_valid    = cmd_valid;
    assign acc_region   = region;
    assign acc_unmapped = cmd_valid & ~(is_ram | is_port | is_timer);

    // no command may reach two targets at once.
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({lanes.sel, port_we, timer_we}))
        else $error("decoder selected more than one target");

endmodule

//--- source/bus_system.sv
`timescale 1ns/10ps

module bus_system #(
    parameter int RAM_BITS        = 8,
    parameter int MHZ_TIMER_VALUE = 4,
    parameter int TIMER_BITS      = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_valid,
    input  logic            cmd_wr,
    input  soc_pkg::addr_t  cmd_addr,
    input  soc_pkg::data_t  cmd_wdata,
    input  soc_pkg::mask_t  cmd_mask,
    output logic            rsp_valid,
    output logic            rsp_error,
    output soc_pkg::data_t  rsp_rdata,
    output logic            led,
    output logic            timer_irq
);

    logic             port_we;
    logic             timer_we;
    logic             acc_valid;
    soc_pkg::region_t acc_region;
    logic             acc_unmapped;
    logic             irq_clear;
    soc_pkg::data_t   timer_count;
    soc_pkg::data_t   ram_rdata;

    lane_if #(.RAM_BITS(RAM_BITS)) lanes ();

    bus_decoder #(.RAM_BITS(RAM_BITS)) u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_wr       (cmd_wr),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_mask     (cmd_mask),
        .lanes        (lanes.master),
        .port_we      (port_we),
        .timer_we     (timer_we),
        .acc_valid    (acc_valid),
        .acc_region   (acc_region),
        .acc_unmapped (acc_unmapped)
    );

    for (genvar i = 0; i < soc_pkg::NUM_LANES; i++) begin : g_lane
        ram_byte_lane #(
            .RAM_BITS (RAM_BITS),
            .LANE     (i)
        ) u_lane (
            .clk   (clk),
            .lanes (lanes.lane),
            .rdata (ram_rdata[8*i +: 8])    // lane i fills byte i of the word.
        );
    end

    port_reg u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (port_we),
        .wdata     (cmd_wdata),
        .mask      (cmd_mask),
        .led       (led),
        .irq_clear (irq_clear)
    );

    mhz_timer #(
        .MHZ_TIMER_VALUE (MHZ_TIMER_VALUE),
        .TIMER_BITS      (TIMER_BITS)
    ) u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (timer_we),
        .value     (cmd_wdata),
        .irq_clear (irq_clear),
        .count     (timer_count),
        .irq       (timer_irq)
    );

    response_mux u_rsp (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_valid    (acc_valid),
        .acc_region   (acc_region),
        .acc_unmapped (acc_unmapped),
        .ram_rdata    (ram_rdata),
        .led          (led),
        .timer_irq    (timer_irq),
        .timer_count  (timer_count),
        .rsp_valid    (rsp_valid),
        .rsp_error    (rsp_error),
        .rsp_rdata    (rsp_rdata)
    );

endmodule

//--- source/lane_if.sv
`timescale 1ns/10ps

interface lane_if #(
    parameter int RAM_BITS = 8
);

    logic                  sel;       // ram access this cycle.
    logic                  wr;
    logic [RAM_BITS-1:0]   word_addr;
    soc_pkg::data_t        wdata;
    soc_pkg::mask_t        mask;

    modport master (
        output sel,
        output wr,
        output word_addr,
        output wdata,
        output mask
    );

    modport lane (
        input sel,
        input wr,
        input word_addr,
        input wdata,
        input mask
    );

endinterface

//--- source/mhz_timer.sv
`timescale 1ns/10ps

module mhz_timer #(
    parameter int MHZ_TIMER_VALUE = 4,
    parameter int TIMER_BITS      = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  soc_pkg::data_t  value,
    input  logic            irq_clear,
    output soc_pkg::data_t  count,
    output logic            irq
);

    localparam int PRE_BITS = (MHZ_TIMER_VALUE > 1) ? $clog2(MHZ_TIMER_VALUE) : 1;
    localparam logic [PRE_BITS-1:0] PRE_LAST = PRE_BITS'(MHZ_TIMER_VALUE - 1);

    soc_pkg::timer_state_e state, state_nxt;
    logic [PRE_BITS-1:0]   prescale, prescale_nxt;
    logic [TIMER_BITS-1:0] count_q, count_nxt;
    logic [TIMER_BITS-1:0] load_val;
    logic                  tick;

    assign load_val = value[TIMER_BITS-1:0];
    assign tick     = (prescale == PRE_LAST);      // one microsecond has passed.

    always_comb begin
        state_nxt    = state;
        prescale_nxt = prescale;
        count_nxt    = count_q;
        if (load) begin
            count_nxt    = load_val;
            prescale_nxt = '0;
            state_nxt    = (load_val == '0) ? soc_pkg::TMR_IDLE : soc_pkg::TMR_COUNT;
        end else begin
            case (state)
                soc_pkg::TMR_COUNT: begin
                    prescale_nxt = tick ? '0 : prescale + 1'b1;
                    if (tick) begin
                        count_nxt = count_q - 1'b1;
                        if (count_q == TIMER_BITS'(1)) begin
                            state_nxt = soc_pkg::TMR_EXPIRED;
                        end
                    end
                end
                soc_pkg::TMR_EXPIRED: begin
                    if (irq_clear) begin
                        state_nxt = soc_pkg::TMR_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= soc_pkg::TMR_IDLE;
            prescale <= '0;
            count_q  <= '0;
            irq      <= 1'b0;
        end else begin
            state    <= state_nxt;
            prescale <= prescale_nxt;
            count_q  <= count_nxt;
            irq      <= (state_nxt == soc_pkg::TMR_EXPIRED) & ~irq_clear;  // clear wins.
        end
    end

    assign count = soc_pkg::data_t'(count_q);

    assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> (state == soc_pkg::TMR_EXPIRED))
        else $error("timer irq high outside expired state");

endmodule

//--- source/port_reg.sv
`timescale 1ns/10ps

module port_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  soc_pkg::data_t  wdata,
    input  soc_pkg::mask_t  mask,
    output logic            led,
    output logic            irq_clear
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led       <= 1'b0;
            irq_clear <= 1'b0;
        end else if (we) begin
            if (mask[0]) begin
                led <= wdata[0];
            end
            if (mask[1]) begin
                irq_clear <= wdata[8];              // held until software writes it back.
            end
        end
    end

endmodule

//--- source/ram_byte_lane.sv
`timescale 1ns/10ps

module ram_byte_lane #(
    parameter int RAM_BITS = 8,
    parameter int LANE     = 0
) (
    input  logic            clk,
    lane_if.lane            lanes,
    output soc_pkg::byte_t  rdata
);

    localparam int DEPTH = 1 << RAM_BITS;

    soc_pkg::byte_t mem [0:DEPTH-1];

    soc_pkg::byte_t wbyte;
    logic           wen;

    assign wbyte = lanes.wdata[8*LANE +: 8];       // this lane's slice of the word.
    assign wen   = lanes.wr & lanes.mask[LANE];

    always_ff @(posedge clk) begin
        if (lanes.sel) begin
            if (wen) begin
                mem[lanes.word_addr] <= wbyte;
            end
            rdata <= mem[lanes.word_addr];          // old contents, read before write.
        end
    end

endmodule

//--- source/response_mux.sv
`timescale 1ns/10ps

module response_mux (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               acc_valid,
    input  soc_pkg::region_t   acc_region,
    input  logic               acc_unmapped,
    input  soc_pkg::data_t     ram_rdata,
    input  logic               led,
    input  logic               timer_irq,
    input  soc_pkg::data_t     timer_count,
    output logic               rsp_valid,
    output logic               rsp_error,
    output soc_pkg::data_t     rsp_rdata
);

    soc_pkg::region_t region_q;
    logic             valid_q;
    logic             unmapped_q;
    soc_pkg::data_t   rdata_sel;

    // first stage, waits for the lane read.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            unmapped_q <= 1'b0;
        end else begin
            valid_q    <= acc_valid;
            unmapped_q <= acc_unmapped;
        end
    end

    always_ff @(posedge clk) begin
        region_q <= acc_region;
    end

    always_comb begin
        case (region_q)
            soc_pkg::REGION_RAM:   rdata_sel = ram_rdata;
            soc_pkg::REGION_PORT:  rdata_sel = {30'd0, timer_irq, led};
            soc_pkg::REGION_TIMER: rdata_sel = timer_count;
            default:               rdata_sel = '0;
        endcase
        if (unmapped_q) begin
            rdata_sel = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_error <= 1'b0;
        end else begin
            rsp_valid <= valid_q;
            rsp_error <= valid_q & unmapped_q;
        end
    end

    always_ff @(posedge clk) begin
        rsp_rdata <= rdata_sel;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_error |-> rsp_valid)
        else $error("error response without valid");

endmodule

//--- source/soc_pkg.sv
package soc_pkg;

    // bus widths.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  mask_t;

    // top address nibble selects the region.
    typedef logic [3:0]  region_t;

    localparam int REGION_LSB = 28;

    localparam region_t REGION_RAM   = 4'd2;
    localparam region_t REGION_PORT  = 4'd3;
    localparam region_t REGION_TIMER = 4'd4;

    // one lane per byte of a data word.
    localparam int NUM_LANES = 4;

    typedef enum logic [1:0] {
        TMR_IDLE,
        TMR_COUNT,
        TMR_EXPIRED
    } timer_state_e;

endpackage

//--- verif/tb_bus_system.sv
`timescale 1ns/10ps

module tb_bus_system;

    localparam int RAM_BITS        = 8;
    localparam int MHZ_TIMER_VALUE = 4;
    localparam int TIMER_BITS      = 16;
    localparam int TIMER_LOAD      = 5;

    logic           clk;
    logic           rst_n;
    logic           cmd_valid;
    logic           cmd_wr;
    soc_pkg::addr_t cmd_addr;
    soc_pkg::data_t cmd_wdata;
    soc_pkg::mask_t cmd_mask;
    logic           rsp_valid;
    logic           rsp_error;
    soc_pkg::data_t rsp_rdata;
    logic           led;
    logic           timer_irq;

    // stimulus table, one entry per command.
    string          row_name [$];
    logic           row_wr [$];
    soc_pkg::addr_t row_addr [$];
    soc_pkg::data_t row_wdata [$];
    soc_pkg::mask_t row_mask [$];
    logic           row_chk [$];
    soc_pkg::data_t row_rdata [$];
    logic           row_err [$];

    soc_pkg::data_t ram_model [0:(1 << RAM_BITS)-1];
    int             seed = 32'h39fadd4d;
    logic           table_ready = 1'b0;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bus_system #(
        .RAM_BITS        (RAM_BITS),
        .MHZ_TIMER_VALUE (MHZ_TIMER_VALUE),
        .TIMER_BITS      (TIMER_BITS)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_wr    (cmd_wr),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_mask  (cmd_mask),
        .rsp_valid (rsp_valid),
        .rsp_error (rsp_error),
        .rsp_rdata (rsp_rdata),
        .led       (led),
        .timer_irq (timer_irq)
    );

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_response(input string name, input logic chk,
                                  input soc_pkg::data_t exp_rdata, input logic exp_err);
        check_value({name, " rsp_valid"}, 32'd1, 32'(rsp_valid));
        check_value({name, " rsp_error"}, 32'(exp_err), 32'(rsp_error));
        if (chk) begin
            check_value({name, " rdata"}, exp_rdata, rsp_rdata);
        end
    endtask

    function automatic soc_pkg::addr_t region_addr(input soc_pkg::region_t region, input int idx);
        soc_pkg::addr_t a;
        a = '0;
        a[soc_pkg::REGION_LSB +: 4] = region;
        a[2 +: RAM_BITS] = idx[RAM_BITS-1:0];       // word index above the byte offset.
        return a;
    endfunction

    function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_word,
                                                   input soc_pkg::data_t new_word,
                                                   input soc_pkg::mask_t mask);
        soc_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < soc_pkg::NUM_LANES; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic add_row(input string name, input logic wr, input soc_pkg::addr_t addr,
                           input soc_pkg::data_t wdata, input soc_pkg::mask_t mask,
                           input logic chk, input soc_pkg::data_t exp_rdata, input logic exp_err);
        row_name.push_back(name);
        row_wr.push_back(wr);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_mask.push_back(mask);
        row_chk.push_back(chk);
        row_rdata.push_back(exp_rdata);
        row_err.push_back(exp_err);
    endtask

    task automatic add_ram_write(input int idx, input soc_pkg::mask_t mask);
        soc_pkg::data_t data;
        data = $random(seed);
        ram_model[idx] = merge_bytes(ram_model[idx], data, mask);
        add_row($sformatf("ram write w%0d m%b", idx, mask), 1'b1,
                region_addr(soc_pkg::REGION_RAM, idx), data, mask, 1'b0, '0, 1'b0);
    endtask

    task automatic add_ram_read(input string tag, input int idx);
        add_row($sformatf("%s read w%0d", tag, idx), 1'b0,
                region_addr(soc_pkg::REGION_RAM, idx), '0, 4'h0, 1'b1, ram_model[idx], 1'b0);
    endtask

    task automatic add_unmapped(input soc_pkg::region_t region, input int idx, input logic wr);
        soc_pkg::data_t data;
        data = $random(seed);
        add_row($sformatf("unmapped region %0d wr %0d", region, wr), wr,
                region_addr(region, idx), data, 4'hf, 1'b1, '0, 1'b1);
    endtask

    task automatic build_table();
        int words [6] = '{3, 17, 42, 100, 200, 255};
        soc_pkg::addr_t port_addr;
        soc_pkg::addr_t timer_addr;
        port_addr  = region_addr(soc_pkg::REGION_PORT, 0);
        timer_addr = region_addr(soc_pkg::REGION_TIMER, 0);
        foreach (words[i]) add_ram_write(words[i], 4'hf);
        foreach (words[i]) add_ram_read("full", words[i]);
        add_ram_write(17, 4'b0001);
        add_ram_write(42, 4'b0110);
        add_ram_write(100, 4'b1010);
        add_ram_write(255, 4'b1000);
        add_ram_write(3, 4'b0000);                  // empty mask leaves the word alone.
        add_ram_read("masked", 17);
        add_ram_read("masked", 42);
        add_ram_read("masked", 100);
        add_ram_read("masked", 255);
        add_ram_read("masked", 3);
        add_unmapped(4'd0, 3, 1'b1);
        add_unmapped(4'd1, 17, 1'b1);
        add_unmapped(4'd5, 42, 1'b1);
        add_unmapped(4'd15, 200, 1'b1);
        add_unmapped(4'd15, 200, 1'b0);
        add_ram_read("after unmapped", 3);
        add_ram_read("after unmapped", 17);
        add_ram_read("after unmapped", 42);
        add_ram_read("after unmapped", 200);
        add_row("port led set", 1'b1, port_addr, 32'h1, 4'b0001, 1'b0, '0, 1'b0);
        add_row("port read led", 1'b0, port_addr, '0, 4'h0, 1'b1, 32'h1, 1'b0);
        add_row("port led masked off", 1'b1, port_addr, 32'h0, 4'b0010, 1'b0, '0, 1'b0);
        add_row("port read led kept", 1'b0, port_addr, '0, 4'h0, 1'b1, 32'h1, 1'b0);
        add_row("timer idle read", 1'b0, timer_addr, '0, 4'h0, 1'b1, 32'h0, 1'b0);
        add_row("timer load nonzero", 1'b1, timer_addr, 32'h9, 4'hf, 1'b0, '0, 1'b0);
        add_row("timer load zero", 1'b1, timer_addr, 32'h0, 4'hf, 1'b0, '0, 1'b0);
        // reads span a full prescaler period, an idle timer never ticks.
        for (int k = 0; k < MHZ_TIMER_VALUE; k++) begin
            add_row("timer read after zero", 1'b0, timer_addr, '0, 4'h0, 1'b1, 32'h0, 1'b0);
        end
    endtask

    task automatic drive_cmd(input logic wr, input soc_pkg::addr_t addr,
                             input soc_pkg::data_t wdata, input soc_pkg::mask_t mask);
        cmd_valid = 1'b1;
        cmd_wr    = wr;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_mask  = mask;
    endtask

    task automatic drive_idle();
        cmd_valid = 1'b0;
        cmd_wr    = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_mask  = '0;
    endtask

    // one command on its own, its response two edges later.
    task automatic single_access(input string name, input logic wr, input soc_pkg::addr_t addr,
                                 input soc_pkg::data_t wdata, input soc_pkg::mask_t mask,
                                 input logic chk, input soc_pkg::data_t exp_rdata);
        drive_cmd(wr, addr, wdata, mask);
        @(posedge clk);
        #1;
        drive_idle();
        @(posedge clk);
        #1;
        check_response(name, chk, exp_rdata, 1'b0);
    endtask

    task automatic run_timer_test();
        int             cyc;
        int             limit;
        soc_pkg::addr_t timer_addr;
        soc_pkg::addr_t port_addr;
        timer_addr = region_addr(soc_pkg::REGION_TIMER, 0);
        port_addr  = region_addr(soc_pkg::REGION_PORT, 0);
        limit      = TIMER_LOAD * MHZ_TIMER_VALUE;
        @(posedge clk);
        #1;
        drive_cmd(1'b1, timer_addr, TIMER_LOAD, 4'hf);
        for (cyc = 1; cyc < limit; cyc++) begin
            @(posedge clk);
            #1;
            drive_idle();
            if (cyc == 2) begin
                check_response("timer load", 1'b0, '0, 1'b0);
                drive_cmd(1'b0, timer_addr, '0, 4'h0);
            end
            if (cyc == 3) begin
                check_value("rsp_valid single pulse", 32'd0, 32'(rsp_valid));
            end
            if (cyc == 4) begin
                check_response("timer count read", 1'b0, '0, 1'b0);
                check_value("timer count in range", 32'd1, 32'(rsp_rdata <= TIMER_LOAD));
            end
            check_value("timer irq low while counting", 32'd0, 32'(timer_irq));
        end
        while (timer_irq !== 1'b1 && cyc <= limit + 2) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        check_value("timer irq rises", 32'd1, 32'(timer_irq));
        single_access("port read irq set", 1'b0, port_addr, '0, 4'h0, 1'b1, 32'h3);
        single_access("irq clear write", 1'b1, port_addr, 32'h101, 4'b0011, 1'b0, '0);
        cyc = 0;
        while (timer_irq !== 1'b0 && cyc < 4) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        check_value("timer irq cleared", 32'd0, 32'(timer_irq));
        single_access("port read irq clear", 1'b0, port_addr, '0, 4'h0, 1'b1, 32'h1);
        single_access("irq clear release", 1'b1, port_addr, 32'h1, 4'b0011, 1'b0, '0);
        single_access("port read idle", 1'b0, port_addr, '0, 4'h0, 1'b1, 32'h1);
    endtask

    initial begin : watchdog
        int budget;
        wait (table_ready === 1'b1);
        budget = row_name.size() + 4 * MHZ_TIMER_VALUE * TIMER_LOAD + 100;
        repeat (budget) @(posedge clk);
        $display("the tests did not finish within %0d cycles", budget);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int n;
        drive_idle();
        build_table();
        n = row_name.size();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
        check_value("reset rsp_error", 32'd0, 32'(rsp_error));
        check_value("reset led", 32'd0, 32'(led));
        check_value("reset timer_irq", 32'd0, 32'(timer_irq));
        // commands go out back to back, each checked two edges after it was driven.
        for (int i = 0; i < n + 2; i++) begin
            @(posedge clk);
            #1;
            if (i >= 2) begin
                check_response(row_name[i-2], row_chk[i-2], row_rdata[i-2], row_err[i-2]);
            end
            if (i < n) begin
                drive_cmd(row_wr[i], row_addr[i], row_wdata[i], row_mask[i]);
            end else begin
                drive_idle();
            end
        end
        check_value("led pin", 32'd1, 32'(led));
        run_timer_test();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS   = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                            // released clear of the edge.
    end

endmodule

//--- vlog.f
source/soc_pkg.sv
source/lane_if.sv
source/bus_decoder.sv
source/ram_byte_lane.sv
source/mhz_timer.sv
source/port_reg.sv
source/response_mux.sv
source/bus_system.sv
verif/tb_clock_gen.sv
verif/tb_bus_system.sv
